// File: lcdPkg.sv
package lcdPkg;

	localparam int DataWidth = 8;
	localparam int PageWidth = 3;
	localparam int ColWidth = 7;
	localparam int ChipCols = 64;

	// Controller opcodes, low bits carry the argument
	localparam logic [DataWidth-1:0] CmdDisplayOn = 8'h3F;
	localparam logic [DataWidth-1:0] CmdStartLine = 8'hC0;
	localparam logic [DataWidth-1:0] CmdSetPage = 8'hB8;
	localparam logic [DataWidth-1:0] CmdSetCol = 8'h40;

	localparam int LabelCols = 16;
	localparam int LevelCol = 24;
	localparam int HeartCol = 80;
	localparam int GlyphCols = 8;

	localparam logic [DataWidth-1:0] labelUpper [LabelCols] = '{
		8'h10, 8'hF0, 8'hF0, 8'h10, 8'h00, 8'h00, 8'h00, 8'h00, // L
		8'h20, 8'hE0, 8'hE0, 8'h00, 8'h00, 8'hE0, 8'hE0, 8'h20  // V
	};

	localparam logic [DataWidth-1:0] labelLower [LabelCols] = '{
		8'h00, 8'h0F, 8'h0F, 8'h0C, 8'h0C, 8'h0C, 8'h0E, 8'h00,
		8'h00, 8'h00, 8'h03, 8'h0E, 8'h0E, 8'h03, 8'h00, 8'h00
	};

	localparam logic [DataWidth-1:0] digitUpper [10][GlyphCols] = '{
		'{8'h00, 8'hE0, 8'h18, 8'h08, 8'h08, 8'h18, 8'hE0, 8'h00},
		'{8'h00, 8'h00, 8'h10, 8'h18, 8'hF8, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h10, 8'h08, 8'h08, 8'h88, 8'h70, 8'h00},
		'{8'h00, 8'h00, 8'h10, 8'h88, 8'h88, 8'h88, 8'h70, 8'h00},
		'{8'h00, 8'h00, 8'h80, 8'h60, 8'h18, 8'hF8, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h78, 8'h48, 8'h48, 8'hC8, 8'h88, 8'h00},
		'{8'h00, 8'hE0, 8'h90, 8'h48, 8'h48, 8'hC8, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h08, 8'h08, 8'h88, 8'h68, 8'h18, 8'h00},
		'{8'h00, 8'h00, 8'h70, 8'h88, 8'h88, 8'h88, 8'h70, 8'h00},
		'{8'h00, 8'h00, 8'hF0, 8'h08, 8'h08, 8'h18, 8'hF0, 8'h00}
	};

	localparam logic [DataWidth-1:0] digitLower [10][GlyphCols] = '{
		'{8'h00, 8'h03, 8'h0C, 8'h08, 8'h08, 8'h0C, 8'h03, 8'h00},
		'{8'h00, 8'h00, 8'h08, 8'h08, 8'h0F, 8'h08, 8'h08, 8'h00},
		'{8'h00, 8'h00, 8'h0C, 8'h0E, 8'h0B, 8'h08, 8'h08, 8'h00},
		'{8'h00, 8'h00, 8'h04, 8'h08, 8'h08, 8'h08, 8'h07, 8'h00},
		'{8'h00, 8'h03, 8'h02, 8'h02, 8'h02, 8'h0F, 8'h02, 8'h00},
		'{8'h00, 8'h00, 8'h04, 8'h08, 8'h08, 8'h0C, 8'h07, 8'h00},
		'{8'h00, 8'h03, 8'h0C, 8'h08, 8'h08, 8'h0C, 8'h07, 8'h00},
		'{8'h00, 8'h00, 8'h00, 8'h0C, 8'h03, 8'h00, 8'h00, 8'h00},
		'{8'h00, 8'h00, 8'h07, 8'h08, 8'h08, 8'h08, 8'h07, 8'h00},
		'{8'h00, 8'h00, 8'h08, 8'h09, 8'h09, 8'h05, 8'h03, 8'h00}
	};

	localparam logic [DataWidth-1:0] heartUpper [GlyphCols] = '{
		8'hC0, 8'hE0, 8'hF0, 8'hE0, 8'hE0, 8'hF0, 8'hE0, 8'hC0
	};

	localparam logic [DataWidth-1:0] heartLower [GlyphCols] = '{
		8'h01, 8'h03, 8'h07, 8'h0F, 8'h0F, 8'h07, 8'h03, 8'h01
	};

	// Bit 0 drives CS1, bit 1 drives CS2
	typedef enum logic [1:0] {
		SelLeft = 2'b01,
		SelRight = 2'b10,
		SelBoth = 2'b11
	} chipSel_e;

	typedef union packed {
		logic [DataWidth-1:0] data;
		struct packed {
			logic [1:0] prefix; // Opcode group
			logic [5:0] arg;    // Page, column or line field
		} cmd;
	} lcdWord_u;

endpackage

// File: glyphRom.sv
`timescale 1ns/1ps

module glyphRom (
	input logic [lcdPkg::ColWidth-1:0] col,
	input logic lowerHalf,
	input logic [3:0] level,
	input logic [2:0] life,
	output logic [lcdPkg::DataWidth-1:0] pattern
);

	localparam int GlyphBits = $clog2(lcdPkg::GlyphCols);

	logic [lcdPkg::ColWidth-1:0] levelOff;
	logic [lcdPkg::ColWidth-1:0] heartOff;
	logic inLabel;
	logic inDigit;
	logic inHeart;

	assign levelOff = col - lcdPkg::ColWidth'(lcdPkg::LevelCol);
	assign heartOff = col - lcdPkg::ColWidth'(lcdPkg::HeartCol);

	assign inLabel = (col < lcdPkg::LabelCols);
	assign inDigit = (col >= lcdPkg::LevelCol) && (col < lcdPkg::LevelCol + lcdPkg::GlyphCols)
		&& (level <= 4'd9); // Two digit levels stay blank
	assign inHeart = (col >= lcdPkg::HeartCol)
		&& (heartOff[lcdPkg::ColWidth-1:GlyphBits] < life); // One glyph per life

	always_comb
	begin
		pattern = '0;
		if (inLabel)
		begin
			if (lowerHalf)
				pattern = lcdPkg::labelLower[col[3:0]];
			else
				pattern = lcdPkg::labelUpper[col[3:0]];
		end
		else if (inDigit)
		begin
			if (lowerHalf)
				pattern = lcdPkg::digitLower[level][levelOff[GlyphBits-1:0]];
			else
				pattern = lcdPkg::digitUpper[level][levelOff[GlyphBits-1:0]];
		end
		else if (inHeart)
		begin
			if (lowerHalf)
				pattern = lcdPkg::heartLower[heartOff[GlyphBits-1:0]];
			else
				pattern = lcdPkg::heartUpper[heartOff[GlyphBits-1:0]];
		end
	end

endmodule

// File: statusFrameProducer.sv
`timescale 1ns/1ps

module statusFrameProducer #(
	parameter int BufDepth = 4
) (
	input logic CLK,
	input logic RESET,
	input logic [6:0] score,
	input logic [2:0] life,
	input logic creditReturn,
	output logic pushValid,
	output lcdPkg::lcdWord_u pushWord,
	output logic pushIsData,
	output lcdPkg::chipSel_e pushSel
);

	localparam int CreditWidth = $clog2(BufDepth + 1);
	localparam logic [1:0] StInit = 2'd0;
	localparam logic [1:0] StPage = 2'd1;
	localparam logic [1:0] StCol = 2'd2;
	localparam logic [1:0] StData = 2'd3;

	logic [1:0] state;
	logic [1:0] initIdx;
	logic [lcdPkg::PageWidth-1:0] page;
	logic [lcdPkg::ColWidth-1:0] col;
	logic clearing;
	logic [3:0] level;
	logic [3:0] levelNext;
	logic [2:0] lifeReg;
	logic [CreditWidth-1:0] credits;
	logic fire;
	logic [lcdPkg::DataWidth-1:0] cmdOp;
	logic [5:0] cmdArg;
	logic [lcdPkg::DataWidth-1:0] pattern;
	lcdPkg::lcdWord_u nextWord;
	logic nextIsData;
	lcdPkg::chipSel_e nextSel;

	glyphRom glyph (
		.col(col),
		.lowerHalf(page[0]),
		.level(level),
		.life(lifeReg),
		.pattern(pattern)
	);

	assign fire = (credits != '0);

	always_comb
	begin
		if (score < 7'd4)
			levelNext = 4'd1;
		else if (score < 7'd10)
			levelNext = 4'd2;
		else if (score < 7'd19)
			levelNext = 4'd3;
		else
			levelNext = 4'(score / 7'd15) + 4'd3;
	end

	always_comb
	begin
		cmdOp = lcdPkg::CmdSetPage;
		cmdArg = '0;
		nextIsData = 1'b0;
		nextSel = lcdPkg::SelBoth;
		case (state)
			StInit:
			begin
				case (initIdx)
					2'd0: cmdOp = lcdPkg::CmdDisplayOn;
					2'd1: cmdOp = lcdPkg::CmdStartLine; // Line 0
					default: cmdOp = lcdPkg::CmdSetPage;
				endcase
			end
			StPage: cmdArg = 6'(page);
			StCol: cmdOp = lcdPkg::CmdSetCol; // Column 0
			default:
			begin
				nextIsData = 1'b1;
				if (!clearing)
					nextSel = col[lcdPkg::ColWidth-1] ? lcdPkg::SelRight : lcdPkg::SelLeft;
			end
		endcase
		if (nextIsData)
			nextWord.data = clearing ? '0 : pattern;
		else
		begin
			nextWord.cmd.prefix = cmdOp[7:6];
			nextWord.cmd.arg = cmdOp[5:0] | cmdArg;
		end
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= StInit;
			initIdx <= '0;
			page <= '0;
			col <= '0;
			clearing <= 1'b1;
			level <= 4'd1;
			lifeReg <= '0;
			pushValid <= 1'b0;
		end
		else
		begin
			pushValid <= fire;
			if (fire)
			begin
				case (state)
					StInit:
					begin
						initIdx <= initIdx + 2'd1;
						if (initIdx == 2'd2)
							state <= StPage;
					end
					StPage:
					begin
						state <= StCol;
						if (!clearing)
						begin
							level <= levelNext; // Held for the whole page
							lifeReg <= life;
						end
					end
					StCol:
						state <= StData;
					default:
					begin
						col <= col + 1'b1;
						if (clearing && col == lcdPkg::ColWidth'(lcdPkg::ChipCols - 1))
						begin
							col <= '0;
							state <= StPage;
							page <= page + 1'b1; // Wraps to page 0 after the last
							if (page == '1)
								clearing <= 1'b0;
						end
						else if (!clearing && col == '1)
						begin
							state <= StPage;
							page <= page ^ lcdPkg::PageWidth'(1); // Upper then lower half
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (fire)
		begin
			pushWord <= nextWord;
			pushIsData <= nextIsData;
			pushSel <= nextSel;
		end
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			credits <= CreditWidth'(BufDepth);
		else
		begin
			case ({fire, creditReturn})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// File: lcdWriteFifo.sv
`timescale 1ns/1ps

module lcdWriteFifo #(
	parameter int BufDepth = 4
) (
	input logic CLK,
	input logic RESET,
	input logic pushValid,
	input lcdPkg::lcdWord_u pushWord,
	input logic pushIsData,
	input lcdPkg::chipSel_e pushSel,
	input logic popReady,
	output logic popValid,
	output lcdPkg::lcdWord_u popWord,
	output logic popIsData,
	output lcdPkg::chipSel_e popSel,
	output logic creditReturn
);

	localparam int PtrWidth = (BufDepth > 1) ? $clog2(BufDepth) : 1;
	localparam int CountWidth = $clog2(BufDepth + 1);

	logic [lcdPkg::DataWidth-1:0] wordMem [BufDepth];
	logic isDataMem [BufDepth];
	lcdPkg::chipSel_e selMem [BufDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	logic pop;

	assign pop = popReady && popValid;
	assign popValid = (count != '0);
	assign popIsData = isDataMem[rdPtr];
	assign popSel = selMem[rdPtr];

	always_comb
		popWord.data = wordMem[rdPtr];

	always_ff @(posedge CLK)
	begin
		if (pushValid)
		begin
			wordMem[wrPtr] <= pushWord.data;
			isDataMem[wrPtr] <= pushIsData;
			selMem[wrPtr] <= pushSel;
		end
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			creditReturn <= pop; // One credit back per drained word
			if (pushValid)
				wrPtr <= (wrPtr == PtrWidth'(BufDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PtrWidth'(BufDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({pushValid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: lcdBusDriver.sv
`timescale 1ns/1ps

module lcdBusDriver #(
	parameter int SetupCycles = 2,
	parameter int PulseCycles = 4,
	parameter int HoldCycles = 2
) (
	input logic CLK,
	input logic RESET,
	input logic popValid,
	input lcdPkg::lcdWord_u popWord,
	input logic popIsData,
	input lcdPkg::chipSel_e popSel,
	output logic popReady,
	output logic [lcdPkg::DataWidth-1:0] lcdData,
	output logic lcdDi,
	output logic lcdCs1,
	output logic lcdCs2,
	output logic lcdEnable,
	output logic lcdRst
);

	localparam int CntWidth = $clog2(SetupCycles + PulseCycles + HoldCycles);
	localparam logic [1:0] DrvIdle = 2'd0;
	localparam logic [1:0] DrvSetup = 2'd1;
	localparam logic [1:0] DrvPulse = 2'd2;
	localparam logic [1:0] DrvHold = 2'd3;

	logic [1:0] state;
	logic [CntWidth-1:0] phaseCnt;

	assign popReady = (state == DrvIdle) && popValid;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= DrvIdle;
			phaseCnt <= '0;
			lcdData <= '0;
			lcdDi <= 1'b0;
			lcdCs1 <= 1'b0;
			lcdCs2 <= 1'b0;
			lcdEnable <= 1'b0;
			lcdRst <= 1'b0;
		end
		else
		begin
			case (state)
				DrvIdle:
				begin
					if (popReady)
					begin
						state <= DrvSetup;
						phaseCnt <= CntWidth'(SetupCycles - 1);
						lcdData <= popWord.data; // Bus held until the hold ends
						lcdDi <= popIsData;
						lcdCs1 <= (popSel == lcdPkg::SelBoth) || (popSel == lcdPkg::SelLeft);
						lcdCs2 <= (popSel == lcdPkg::SelBoth) || (popSel == lcdPkg::SelRight);
						lcdRst <= 1'b1; // Panel out of reset from first cycle on
					end
				end
				DrvSetup:
				begin
					phaseCnt <= phaseCnt - 1'b1;
					if (phaseCnt == '0)
					begin
						state <= DrvPulse;
						phaseCnt <= CntWidth'(PulseCycles - 1);
						lcdEnable <= 1'b1;
					end
				end
				DrvPulse:
				begin
					phaseCnt <= phaseCnt - 1'b1;
					if (phaseCnt == '0)
					begin
						state <= DrvHold;
						phaseCnt <= CntWidth'(HoldCycles - 1);
						lcdEnable <= 1'b0; // Panel latches on this fall
					end
				end
				default:
				begin
					phaseCnt <= phaseCnt - 1'b1;
					if (phaseCnt == '0)
						state <= DrvIdle;
				end
			endcase
		end
	end

endmodule

// File: lcdStatusDisplay.sv
`timescale 1ns/1ps

module lcdStatusDisplay #(
	parameter int BufDepth = 4,
	parameter int SetupCycles = 2,
	parameter int PulseCycles = 4,
	parameter int HoldCycles = 2
) (
	input logic CLK,
	input logic RESET,
	input logic [6:0] score,
	input logic [2:0] life,
	output logic LCD_ENABLE,
	output logic LCD_RW,
	output logic LCD_DI,
	output logic LCD_CS1,
	output logic LCD_CS2,
	output logic LCD_RST,
	output logic [lcdPkg::DataWidth-1:0] LCD_DATA
);

	logic pushValid;
	lcdPkg::lcdWord_u pushWord;
	logic pushIsData;
	lcdPkg::chipSel_e pushSel;
	logic creditReturn;
	logic popReady;
	logic popValid;
	lcdPkg::lcdWord_u popWord;
	logic popIsData;
	lcdPkg::chipSel_e popSel;

	assign LCD_RW = 1'b0; // Write only, status never read back

	statusFrameProducer #(
		.BufDepth(BufDepth)
	) producer (
		.CLK(CLK),
		.RESET(RESET),
		.score(score),
		.life(life),
		.creditReturn(creditReturn),
		.pushValid(pushValid),
		.pushWord(pushWord),
		.pushIsData(pushIsData),
		.pushSel(pushSel)
	);

	lcdWriteFifo #(
		.BufDepth(BufDepth)
	) writeFifo (
		.CLK(CLK),
		.RESET(RESET),
		.pushValid(pushValid),
		.pushWord(pushWord),
		.pushIsData(pushIsData),
		.pushSel(pushSel),
		.popReady(popReady),
		.popValid(popValid),
		.popWord(popWord),
		.popIsData(popIsData),
		.popSel(popSel),
		.creditReturn(creditReturn)
	);

	lcdBusDriver #(
		.SetupCycles(SetupCycles),
		.PulseCycles(PulseCycles),
		.HoldCycles(HoldCycles)
	) busDriver (
		.CLK(CLK),
		.RESET(RESET),
		.popValid(popValid),
		.popWord(popWord),
		.popIsData(popIsData),
		.popSel(popSel),
		.popReady(popReady),
		.lcdData(LCD_DATA),
		.lcdDi(LCD_DI),
		.lcdCs1(LCD_CS1),
		.lcdCs2(LCD_CS2),
		.lcdEnable(LCD_ENABLE),
		.lcdRst(LCD_RST)
	);

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int Period = 20,
	parameter int ResetCycles = 10
) (
	output logic CLK,
	output logic RESET
);

	initial
	begin
		CLK = 1'b0;
		forever
			#(Period / 2) CLK = ~CLK;
	end

	initial
	begin
		RESET = 1'b0;
		repeat (ResetCycles) @(posedge CLK);
		@(negedge CLK);
		RESET <= 1'b1; // Release lands after the falling edge samples
	end

endmodule

// File: lcdStatusDisplayTb.sv
`timescale 1ns/1ps

module lcdStatusDisplayTb;

	localparam int SetupCycles = 2;
	localparam int PulseCycles = 4;
	localparam int HoldCycles = 2;
	localparam int InitWords = 3;
	localparam int ClearPages = 8;
	localparam int ClearWords = 2 + lcdPkg::ChipCols;
	localparam int StatusWords = 2 + 2 * lcdPkg::ChipCols;
	localparam int StatusPages = 10; // Two fixed pages, then eight score and life vectors
	localparam int MinSpacing = SetupCycles + PulseCycles + HoldCycles + 1;
	localparam int TimeoutCycles = (1 + ClearPages + StatusPages) * StatusWords
		* (SetupCycles + PulseCycles + HoldCycles + 2) + 2000;
	localparam logic [7:0] InitSeq [InitWords] = '{
		lcdPkg::CmdDisplayOn, lcdPkg::CmdStartLine, lcdPkg::CmdSetPage
	};

	logic CLK;
	logic RESET;
	logic [6:0] score;
	logic [2:0] life;
	logic LCD_ENABLE;
	logic LCD_RW;
	logic LCD_DI;
	logic LCD_CS1;
	logic LCD_CS2;
	logic LCD_RST;
	logic [lcdPkg::DataWidth-1:0] LCD_DATA;

	int seed;
	int cycleCount;
	int sampleCount;
	int lastRise;
	int highCycles;
	int wordIdx;
	int modelLevel;
	int modelLife;
	bit prevEnable;
	bit seenStrobe;
	bit finished;
	logic wrDi;
	logic [1:0] wrCs; // {CS2, CS1}
	logic [7:0] wrData;
	int scoreList [6] = '{0, 3, 4, 18, 19, 127};

	tbClock #(
		.Period(20),
		.ResetCycles(10)
	) clockGen (
		.CLK(CLK),
		.RESET(RESET)
	);

	lcdStatusDisplay UUT (
		.CLK(CLK),
		.RESET(RESET),
		.score(score),
		.life(life),
		.LCD_ENABLE(LCD_ENABLE),
		.LCD_RW(LCD_RW),
		.LCD_DI(LCD_DI),
		.LCD_CS1(LCD_CS1),
		.LCD_CS2(LCD_CS2),
		.LCD_RST(LCD_RST),
		.LCD_DATA(LCD_DATA)
	);

	task automatic abortRun();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAILED %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
		abortRun();
	endtask

	function automatic int levelFor(input int s);
		if (s < 4)
			return 1;
		if (s < 10)
			return 2;
		if (s < 19)
			return 3;
		return s / 15 + 3;
	endfunction

	function automatic string regionName(input int c);
		if (c < lcdPkg::LabelCols)
			return "label";
		if (c >= lcdPkg::LevelCol && c < lcdPkg::LevelCol + lcdPkg::GlyphCols)
			return "level digit";
		if (c >= lcdPkg::HeartCol)
			return "hearts";
		return "blank";
	endfunction

	function automatic logic [7:0] refPattern(input int c, input bit lower, input int lvl,
		input int lives);
		int h;
		int base;
		logic [7:0] result;
		result = 8'h00;
		if (c < lcdPkg::LabelCols)
			result = lower ? lcdPkg::labelLower[c] : lcdPkg::labelUpper[c];
		else if (c >= lcdPkg::LevelCol && c < lcdPkg::LevelCol + lcdPkg::GlyphCols)
		begin
			if (lvl <= 9) // Levels of two digits stay blank
				result = lower ? lcdPkg::digitLower[lvl][c - lcdPkg::LevelCol]
					: lcdPkg::digitUpper[lvl][c - lcdPkg::LevelCol];
		end
		else
		begin
			for (h = 0; h < lives; h++)
			begin
				base = lcdPkg::HeartCol + h * lcdPkg::GlyphCols;
				if (c >= base && c < base + lcdPkg::GlyphCols)
					result = lower ? lcdPkg::heartLower[c - base] : lcdPkg::heartUpper[c - base];
			end
		end
		return result;
	endfunction

	task automatic checkResetState();
		assert (LCD_ENABLE === 1'b0) else reportMismatch("reset ENABLE", 0, LCD_ENABLE);
		assert (LCD_RST === 1'b0) else reportMismatch("reset LCD_RST", 0, LCD_RST);
		assert (LCD_DI === 1'b0) else reportMismatch("reset DI", 0, LCD_DI);
		assert ({LCD_CS2, LCD_CS1} === 2'b00)
			else reportMismatch("reset CS2/CS1", 0, {LCD_CS2, LCD_CS1});
		assert (LCD_DATA === 8'h00) else reportMismatch("reset DATA", 0, LCD_DATA);
	endtask

	task automatic compareWrite(input string testName, input logic expDi,
		input logic [1:0] expCs, input logic [7:0] expData);
		assert (wrDi === expDi) else reportMismatch({testName, " DI"}, expDi, wrDi);
		assert (wrCs === expCs) else reportMismatch({testName, " CS2/CS1"}, expCs, wrCs);
		assert (wrData === expData) else reportMismatch({testName, " DATA"}, expData, wrData);
	endtask

	// Inputs for the next status page, set well before its start
	task automatic applyNextInputs(input int nextPage);
		int vec;
		vec = nextPage - 2;
		if (vec >= 0)
		begin
			life = 3'(vec);
			if (vec < 6)
				score = 7'(scoreList[vec]);
			else
				score = 7'($random(seed));
		end
	endtask

	task automatic checkStatusWord(input int k);
		int page;
		int col;
		page = k / StatusWords;
		col = k % StatusWords - 2;
		if (col == -2)
		begin
			modelLevel = levelFor(score); // Inputs unchanged since mid previous page
			modelLife = life;
			compareWrite($sformatf("status %0d set page", page), 1'b0, 2'b11,
				lcdPkg::CmdSetPage | 8'(page % 2));
		end
		else if (col == -1)
			compareWrite($sformatf("status %0d set column", page), 1'b0, 2'b11, lcdPkg::CmdSetCol);
		else
		begin
			compareWrite($sformatf("status %0d %s col %0d", page, regionName(col), col), 1'b1,
				(col < lcdPkg::ChipCols) ? 2'b01 : 2'b10,
				refPattern(col, page % 2, modelLevel, modelLife));
			if (col == lcdPkg::ChipCols)
				applyNextInputs(page + 1);
			if (col == 2 * lcdPkg::ChipCols - 1 && page == StatusPages - 1)
				finished = 1'b1;
		end
	endtask

	task automatic checkWrite();
		int k;
		int page;
		if (wordIdx < InitWords)
			compareWrite($sformatf("init word %0d", wordIdx), 1'b0, 2'b11, InitSeq[wordIdx]);
		else if (wordIdx < InitWords + ClearPages * ClearWords)
		begin
			k = wordIdx - InitWords;
			page = k / ClearWords;
			case (k % ClearWords)
				0: compareWrite($sformatf("clear %0d set page", page), 1'b0, 2'b11,
					lcdPkg::CmdSetPage | 8'(page));
				1: compareWrite($sformatf("clear %0d set column", page), 1'b0, 2'b11,
					lcdPkg::CmdSetCol);
				default: compareWrite($sformatf("clear %0d data %0d", page, k % ClearWords - 2),
					1'b1, 2'b11, 8'h00);
			endcase
		end
		else
			checkStatusWord(wordIdx - InitWords - ClearPages * ClearWords);
		wordIdx++;
	endtask

	// One call per falling clock edge, a write is taken at each ENABLE fall
	task automatic sampleBus();
		sampleCount++;
		assert (LCD_RW === 1'b0) else reportMismatch("LCD_RW tied low", 0, LCD_RW);
		if (LCD_ENABLE && !prevEnable)
		begin
			if (seenStrobe)
			begin
				assert (sampleCount - lastRise >= MinSpacing)
					else reportMismatch("ENABLE rise spacing min", MinSpacing, sampleCount - lastRise);
			end
			lastRise = sampleCount;
			seenStrobe = 1'b1;
			highCycles = 1;
			wrDi = LCD_DI;
			wrCs = {LCD_CS2, LCD_CS1};
			wrData = LCD_DATA;
		end
		else if (LCD_ENABLE)
			highCycles++;
		else if (prevEnable)
		begin
			assert (highCycles == PulseCycles)
				else reportMismatch("ENABLE pulse width", PulseCycles, highCycles);
			checkWrite();
		end
		if (LCD_ENABLE || prevEnable)
		begin
			assert ({LCD_DI, LCD_CS2, LCD_CS1, LCD_DATA} === {wrDi, wrCs, wrData})
				else reportMismatch("bus stable in strobe", {wrDi, wrCs, wrData},
					{LCD_DI, LCD_CS2, LCD_CS1, LCD_DATA});
		end
		if (seenStrobe)
		begin
			assert (LCD_RST === 1'b1) else reportMismatch("LCD_RST after first strobe", 1, LCD_RST);
		end
		prevEnable = LCD_ENABLE;
	endtask

	always @(posedge CLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout after %0d cycles, status pages not completed", cycleCount);
			abortRun();
		end
	end

	initial
	begin
		seed = 21;
		score = 7'd12; // Level 3 for the fixed layout pages
		life = 3'd3;
		cycleCount = 0;
		sampleCount = 0;
		lastRise = 0;
		highCycles = 0;
		wordIdx = 0;
		modelLevel = 0;
		modelLife = 0;
		prevEnable = 1'b0;
		seenStrobe = 1'b0;
		finished = 1'b0;
		wrDi = 1'b0;
		wrCs = 2'b00;
		wrData = 8'h00;
		@(negedge CLK);
		while (RESET !== 1'b1)
		begin
			checkResetState();
			@(negedge CLK);
		end
		while (!finished)
		begin
			sampleBus();
			@(negedge CLK);
		end
		$display("All checks passed");
		$finish;
	end

endmodule

// File: lcdStatusDisplay.f
lcdPkg.sv
glyphRom.sv
statusFrameProducer.sv
lcdWriteFifo.sv
lcdBusDriver.sv
lcdStatusDisplay.sv
tbClock.sv
lcdStatusDisplayTb.sv
